/* include/dbg_defs.svh */
/*
 * Debug subsystem widths and constants
 * Shared by the RTL blocks and the testbench
 */

`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

// Data bus and AHB address width
`define DBG_XLEN 32

// CPU debug register address width
`define DBG_CPU_AW 16

// JTAG instruction register width
`define DBG_IR_W 4

// Debug data register length
// Layout {op, addr, data}, data leaves on TDO first, op is shifted in last
`define DBG_DR_W 67

// IDCODE value, bit 0 set as 1149.1 requires
`define DBG_IDCODE 32'h1000_0DDD

// Synchronizer depth on the JTAG pins
`define DBG_SYNC_STAGES 2

`endif

/* hdl/dbg_pkg.sv */
/*
 * Debug subsystem types
 * TAP states, JTAG instructions and debug command opcodes
 */

`include "dbg_defs.svh"

package dbg_pkg;

  // IEEE 1149.1 TAP controller states
  typedef enum logic [3:0] {
    TAP_RESET, TAP_IDLE,
    TAP_SEL_DR, TAP_CAP_DR, TAP_SH_DR, TAP_EX1_DR, TAP_PA_DR, TAP_EX2_DR, TAP_UPD_DR,
    TAP_SEL_IR, TAP_CAP_IR, TAP_SH_IR, TAP_EX1_IR, TAP_PA_IR, TAP_EX2_IR, TAP_UPD_IR
  } tap_state_e;

  // Instructions, any other code selects BYPASS
  typedef enum logic [`DBG_IR_W-1:0] {
    TAP_IR_IDCODE = 4'h1,
    TAP_IR_DEBUG  = 4'h8,
    TAP_IR_BYPASS = 4'hF
  } tap_instr_e;

  // Debug commands, top field of the data register
  typedef enum logic [2:0] {
    OP_NOP    = 3'd0,
    OP_MEM_RD = 3'd1,
    OP_MEM_WR = 3'd2,
    OP_CPU_RD = 3'd3,
    OP_CPU_WR = 3'd4,
    OP_CTRL   = 3'd5
  } dbg_op_e;

endpackage

/* hdl/dbg_ifs.sv */
/*
 * Debug subsystem interfaces
 * dbg_tap_if links the TAP to the debug register
 * dbg_req_if carries one command to a memory or CPU target
 */

`timescale 1ns/100ps

`include "dbg_defs.svh"

interface dbg_tap_if;
  // One-cycle tck edge strobes
  logic tck_rise;
  logic tck_fall;
  // DEBUG instruction loaded
  logic sel;
  // DR state flags, update is a pulse on entry
  logic capture;
  logic shift;
  logic update;
  // Serial data in and out of the debug register
  logic tdi;
  logic tdo;

  modport tap (output tck_rise, tck_fall, sel, capture, shift, update, tdi, input tdo);
  modport dr  (input tck_rise, sel, capture, shift, update, tdi, output tdo);
endinterface

interface dbg_req_if;
  // Request side, req is one cycle wide
  logic                 req;
  logic                 we;
  logic [`DBG_XLEN-1:0] addr;
  logic [`DBG_XLEN-1:0] wdata;
  // Response side, rdata and err valid with done
  logic [`DBG_XLEN-1:0] rdata;
  logic                 done;
  logic                 err;

  modport master (output req, we, addr, wdata, input rdata, done, err);
  modport target (input req, we, addr, wdata, output rdata, done, err);
endinterface

/* hdl/dbg_tap_ctrl.sv */
/*
 * JTAG TAP controller
 * Oversamples the JTAG pins in the hclk domain, runs the 1149.1 state
 * machine and holds the IR, IDCODE and BYPASS registers
 */

`timescale 1ns/100ps

`include "dbg_defs.svh"

module dbg_tap_ctrl (
  input  logic hclk_i,
  input  logic rst_n_i,
  input  logic jtag_tck_i,
  input  logic jtag_tms_i,
  input  logic jtag_tdi_i,
  output logic jtag_tdo_o,
  output logic jtag_tdo_oe_o,
  dbg_tap_if.tap tap
);

  localparam int SYNC = `DBG_SYNC_STAGES;
  localparam int IRW  = `DBG_IR_W;

  logic [SYNC-1:0]      tck_sync_q, tms_sync_q, tdi_sync_q;
  logic                 tck_prev_q;
  logic                 tck_rise_q, tck_fall_q;
  logic                 tms, tdi;
  dbg_pkg::tap_state_e  state_q, state_nxt;
  logic [IRW-1:0]       ir_shift_q, ir_q;
  logic [31:0]          idcode_q;
  logic                 bypass_q;
  logic                 upd_dr_q;
  logic                 tdo_q, tdo_oe_q;

  assign tms = tms_sync_q[SYNC-1];
  assign tdi = tdi_sync_q[SYNC-1];

  //////////////////////////////
  // Pin sync and edge detect
  //////////////////////////////

  // Strobes land 3 hclk after a tck pin edge
  always_ff @(posedge hclk_i) begin
    if (!rst_n_i) begin
      tck_sync_q <= '0;
      tms_sync_q <= '1;
      tdi_sync_q <= '0;
      tck_prev_q <= 1'b0;
      tck_rise_q <= 1'b0;
      tck_fall_q <= 1'b0;
    end else begin
      tck_sync_q <= {tck_sync_q[SYNC-2:0], jtag_tck_i};
      tms_sync_q <= {tms_sync_q[SYNC-2:0], jtag_tms_i};
      tdi_sync_q <= {tdi_sync_q[SYNC-2:0], jtag_tdi_i};
      tck_prev_q <= tck_sync_q[SYNC-1];
      tck_rise_q <= tck_sync_q[SYNC-1] & ~tck_prev_q;
      tck_fall_q <= ~tck_sync_q[SYNC-1] & tck_prev_q;
    end
  end

  //////////////////////////////
  // TAP state machine
  //////////////////////////////

  always_comb begin
    case (state_q)
      dbg_pkg::TAP_RESET:  state_nxt = tms ? dbg_pkg::TAP_RESET  : dbg_pkg::TAP_IDLE;
      dbg_pkg::TAP_IDLE:   state_nxt = tms ? dbg_pkg::TAP_SEL_DR : dbg_pkg::TAP_IDLE;
      dbg_pkg::TAP_SEL_DR: state_nxt = tms ? dbg_pkg::TAP_SEL_IR : dbg_pkg::TAP_CAP_DR;
      dbg_pkg::TAP_CAP_DR: state_nxt = tms ? dbg_pkg::TAP_EX1_DR : dbg_pkg::TAP_SH_DR;
      dbg_pkg::TAP_SH_DR:  state_nxt = tms ? dbg_pkg::TAP_EX1_DR : dbg_pkg::TAP_SH_DR;
      dbg_pkg::TAP_EX1_DR: state_nxt = tms ? dbg_pkg::TAP_UPD_DR : dbg_pkg::TAP_PA_DR;
      dbg_pkg::TAP_PA_DR:  state_nxt = tms ? dbg_pkg::TAP_EX2_DR : dbg_pkg::TAP_PA_DR;
      dbg_pkg::TAP_EX2_DR: state_nxt = tms ? dbg_pkg::TAP_UPD_DR : dbg_pkg::TAP_SH_DR;
      dbg_pkg::TAP_UPD_DR: state_nxt = tms ? dbg_pkg::TAP_SEL_DR : dbg_pkg::TAP_IDLE;
      dbg_pkg::TAP_SEL_IR: state_nxt = tms ? dbg_pkg::TAP_RESET  : dbg_pkg::TAP_CAP_IR;
      dbg_pkg::TAP_CAP_IR: state_nxt = tms ? dbg_pkg::TAP_EX1_IR : dbg_pkg::TAP_SH_IR;
      dbg_pkg::TAP_SH_IR:  state_nxt = tms ? dbg_pkg::TAP_EX1_IR : dbg_pkg::TAP_SH_IR;
      dbg_pkg::TAP_EX1_IR: state_nxt = tms ? dbg_pkg::TAP_UPD_IR : dbg_pkg::TAP_PA_IR;
      dbg_pkg::TAP_PA_IR:  state_nxt = tms ? dbg_pkg::TAP_EX2_IR : dbg_pkg::TAP_PA_IR;
      dbg_pkg::TAP_EX2_IR: state_nxt = tms ? dbg_pkg::TAP_UPD_IR : dbg_pkg::TAP_SH_IR;
      dbg_pkg::TAP_UPD_IR: state_nxt = tms ? dbg_pkg::TAP_SEL_DR : dbg_pkg::TAP_IDLE;
      default:             state_nxt = dbg_pkg::TAP_RESET;
    endcase
  end

  always_ff @(posedge hclk_i) begin
    if (!rst_n_i) begin
      state_q  <= dbg_pkg::TAP_RESET;
      ir_q     <= dbg_pkg::TAP_IR_IDCODE;
      upd_dr_q <= 1'b0;
      tdo_q    <= 1'b0;
      tdo_oe_q <= 1'b0;
    end else begin
      // Pulse in the first cycle of Update-DR
      upd_dr_q <= tck_rise_q && (state_nxt == dbg_pkg::TAP_UPD_DR);
      if (tck_rise_q) begin
        state_q <= state_nxt;
        // IR takes the shifted value on entry to Update-IR
        if (state_nxt == dbg_pkg::TAP_UPD_IR)
          ir_q <= ir_shift_q;
        else if (state_q == dbg_pkg::TAP_RESET)
          ir_q <= dbg_pkg::TAP_IR_IDCODE;
      end
      // TDO moves on the falling tck edge
      if (tck_fall_q) begin
        tdo_oe_q <= (state_q == dbg_pkg::TAP_SH_IR) || (state_q == dbg_pkg::TAP_SH_DR);
        if (state_q == dbg_pkg::TAP_SH_IR)
          tdo_q <= ir_shift_q[0];
        else if (ir_q == dbg_pkg::TAP_IR_IDCODE)
          tdo_q <= idcode_q[0];
        else if (ir_q == dbg_pkg::TAP_IR_DEBUG)
          tdo_q <= tap.tdo;
        else
          tdo_q <= bypass_q;
      end
    end
  end

  //////////////////////////////
  // IR, IDCODE and BYPASS shift
  //////////////////////////////

  always_ff @(posedge hclk_i) begin
    if (tck_rise_q) begin
      case (state_q)
        dbg_pkg::TAP_CAP_IR: ir_shift_q <= 4'b0001;
        dbg_pkg::TAP_SH_IR:  ir_shift_q <= {tdi, ir_shift_q[IRW-1:1]};
        dbg_pkg::TAP_CAP_DR: begin
          idcode_q <= `DBG_IDCODE;
          bypass_q <= 1'b0;
        end
        dbg_pkg::TAP_SH_DR: begin
          idcode_q <= {tdi, idcode_q[31:1]};
          bypass_q <= tdi;
        end
        default: ;
      endcase
    end
  end

  // Debug register side
  assign tap.tck_rise = tck_rise_q;
  assign tap.tck_fall = tck_fall_q;
  assign tap.sel      = (ir_q == dbg_pkg::TAP_IR_DEBUG);
  assign tap.capture  = (state_q == dbg_pkg::TAP_CAP_DR);
  assign tap.shift    = (state_q == dbg_pkg::TAP_SH_DR);
  assign tap.update   = upd_dr_q;
  assign tap.tdi      = tdi;

  assign jtag_tdo_o    = tdo_q;
  assign jtag_tdo_oe_o = tdo_oe_q;

endmodule

/* hdl/dbg_cmd_unit.sv */
/*
 * Debug command unit
 * Shifts the 67-bit debug register, decodes commands on Update-DR and
 * sends them to the memory or CPU target
 * Owns the stall, reset and status registers
 */

`timescale 1ns/100ps

`include "dbg_defs.svh"

module dbg_cmd_unit (
  input  logic hclk_i,
  input  logic rst_n_i,
  dbg_tap_if.dr     tap,
  dbg_req_if.master mem,
  dbg_req_if.master cpu,
  input  logic cpu_bp_i,
  output logic cpu_stall_o,
  output logic sys_rst_o
);

  localparam int XW  = `DBG_XLEN;
  localparam int DRW = `DBG_DR_W;

  logic [DRW-1:0]    dr_q;
  dbg_pkg::dbg_op_e  op;
  logic [XW-1:0]     cmd_addr, cmd_data;
  logic              upd_fire;
  logic              mem_req_q, cpu_req_q;
  logic              we_q;
  logic [XW-1:0]     addr_q, wdata_q, rdata_q;
  logic              busy_q, err_q, stall_q, sys_rst_q, bp_seen_q, bp_q;
  logic              done, done_err;
  logic [XW-1:0]     done_rdata;

  // Field split of the shifted register
  assign op       = dbg_pkg::dbg_op_e'(dr_q[DRW-1 -: 3]);
  assign cmd_addr = dr_q[XW +: XW];
  assign cmd_data = dr_q[0 +: XW];
  assign upd_fire = tap.update & tap.sel;

  // Only one target is ever busy
  assign done       = mem.done | cpu.done;
  assign done_rdata = mem.done ? mem.rdata : cpu.rdata;
  assign done_err   = (mem.done & mem.err) | (cpu.done & cpu.err);

  //////////////////////////////
  // Debug data register
  //////////////////////////////

  // Capture loads status with the op field as NOP
  always_ff @(posedge hclk_i) begin
    if (tap.tck_rise && tap.sel) begin
      if (tap.capture)
        dr_q <= {3'b000, {(XW-4){1'b0}}, bp_seen_q, stall_q, err_q, busy_q, rdata_q};
      else if (tap.shift)
        dr_q <= {tap.tdi, dr_q[DRW-1:1]};
    end
  end

  assign tap.tdo = dr_q[0];

  // Command fields held for the target
  always_ff @(posedge hclk_i) begin
    if (upd_fire && !busy_q) begin
      we_q    <= (op == dbg_pkg::OP_MEM_WR) || (op == dbg_pkg::OP_CPU_WR);
      wdata_q <= cmd_data;
      addr_q  <= cmd_addr;
    end
    if (done && !we_q)
      rdata_q <= done_rdata;
  end

  //////////////////////////////
  // Dispatch and status
  //////////////////////////////

  always_ff @(posedge hclk_i) begin
    if (!rst_n_i) begin
      mem_req_q <= 1'b0;
      cpu_req_q <= 1'b0;
      busy_q    <= 1'b0;
      err_q     <= 1'b0;
      stall_q   <= 1'b0;
      sys_rst_q <= 1'b0;
      bp_seen_q <= 1'b0;
      bp_q      <= 1'b0;
    end else begin
      mem_req_q <= 1'b0;
      cpu_req_q <= 1'b0;
      bp_q      <= cpu_bp_i;
      if (done) begin
        busy_q <= 1'b0;
        err_q  <= err_q | done_err;
      end
      // Breakpoint edge halts the core
      if (cpu_bp_i && !bp_q) begin
        stall_q   <= 1'b1;
        bp_seen_q <= 1'b1;
      end
      if (upd_fire) begin
        if (busy_q)
          // Dropped command
          err_q <= 1'b1;
        else begin
          case (op)
            dbg_pkg::OP_MEM_RD, dbg_pkg::OP_MEM_WR: begin
              mem_req_q <= 1'b1;
              busy_q    <= 1'b1;
            end
            dbg_pkg::OP_CPU_RD, dbg_pkg::OP_CPU_WR: begin
              cpu_req_q <= 1'b1;
              busy_q    <= 1'b1;
            end
            dbg_pkg::OP_CTRL: begin
              stall_q   <= cmd_data[0];
              sys_rst_q <= cmd_data[1];
              // Bit 2 clears the sticky flags
              if (cmd_data[2]) begin
                err_q     <= 1'b0;
                bp_seen_q <= 1'b0;
              end
            end
            default: ;
          endcase
        end
      end
    end
  end

  assign mem.req   = mem_req_q;
  assign mem.we    = we_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;
  assign cpu.req   = cpu_req_q;
  assign cpu.we    = we_q;
  assign cpu.addr  = addr_q;
  assign cpu.wdata = wdata_q;

  assign cpu_stall_o = stall_q;
  assign sys_rst_o   = sys_rst_q;

endmodule

/* hdl/dbg_ahb_master.sv */
/*
 * Debug AHB-Lite master
 * One NONSEQ word transfer per request, no bursts
 */

`timescale 1ns/100ps

`include "dbg_defs.svh"

module dbg_ahb_master (
  input  logic                 hclk_i,
  input  logic                 rst_n_i,
  dbg_req_if.target            req,
  output logic                 hsel_o,
  output logic [`DBG_XLEN-1:0] haddr_o,
  output logic [`DBG_XLEN-1:0] hwdata_o,
  input  logic [`DBG_XLEN-1:0] hrdata_i,
  output logic                 hwrite_o,
  output logic [2:0]           hsize_o,
  output logic [1:0]           htrans_o,
  input  logic                 hready_i,
  input  logic                 hresp_i
);

  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [2:0] HSIZE_WORD    = 3'b010;

  typedef enum logic [1:0] {AHB_IDLE, AHB_ADDR, AHB_DATA} ahb_state_e;

  ahb_state_e           state_q;
  logic                 hsel_q;
  logic [1:0]           htrans_q;
  logic                 hwrite_q;
  logic [`DBG_XLEN-1:0] haddr_q, hwdata_q, rdata_q;
  logic                 done_q, err_q;

  always_ff @(posedge hclk_i) begin
    if (!rst_n_i) begin
      state_q  <= AHB_IDLE;
      hsel_q   <= 1'b0;
      htrans_q <= HTRANS_IDLE;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        AHB_IDLE: if (req.req) begin
          state_q  <= AHB_ADDR;
          hsel_q   <= 1'b1;
          htrans_q <= HTRANS_NONSEQ;
        end
        // Single address phase, then idle on the bus
        AHB_ADDR: begin
          state_q  <= AHB_DATA;
          hsel_q   <= 1'b0;
          htrans_q <= HTRANS_IDLE;
        end
        // Wait states stretch this phase
        AHB_DATA: if (hready_i) begin
          state_q <= AHB_IDLE;
          done_q  <= 1'b1;
        end
        default: state_q <= AHB_IDLE;
      endcase
    end
  end

  // Address and data held across the whole transfer
  always_ff @(posedge hclk_i) begin
    if (state_q == AHB_IDLE && req.req) begin
      haddr_q  <= req.addr;
      hwrite_q <= req.we;
      hwdata_q <= req.wdata;
    end
    if (state_q == AHB_DATA && hready_i) begin
      rdata_q <= hrdata_i;
      err_q   <= hresp_i;
    end
  end

  assign hsel_o   = hsel_q;
  assign htrans_o = htrans_q;
  assign haddr_o  = haddr_q;
  assign hwrite_o = hwrite_q;
  assign hwdata_o = hwdata_q;
  assign hsize_o  = HSIZE_WORD;

  assign req.done  = done_q;
  assign req.rdata = rdata_q;
  assign req.err   = err_q;

endmodule

/* hdl/dbg_cpu_port.sv */
/*
 * CPU debug register port
 * Holds strobe, address and write data until the core acks
 */

`timescale 1ns/100ps

`include "dbg_defs.svh"

module dbg_cpu_port (
  input  logic                 hclk_i,
  input  logic                 rst_n_i,
  dbg_req_if.target            req,
  output logic                 cpu_strb_o,
  output logic                 cpu_we_o,
  output logic [`DBG_XLEN-1:0] cpu_addr_o,
  output logic [`DBG_XLEN-1:0] cpu_dati_o,
  input  logic [`DBG_XLEN-1:0] cpu_dato_i,
  input  logic                 cpu_ack_i
);

  logic                 strb_q, done_q, we_q;
  logic [`DBG_XLEN-1:0] addr_q, dati_q, rdata_q;

  // Strobe from the cycle after req up to ack
  always_ff @(posedge hclk_i) begin
    if (!rst_n_i) begin
      strb_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (!strb_q && req.req)
        strb_q <= 1'b1;
      else if (strb_q && cpu_ack_i) begin
        strb_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge hclk_i) begin
    if (!strb_q && req.req) begin
      we_q   <= req.we;
      addr_q <= req.addr;
      dati_q <= req.wdata;
    end
    // Read data sampled on the ack cycle
    if (strb_q && cpu_ack_i)
      rdata_q <= cpu_dato_i;
  end

  assign cpu_strb_o = strb_q;
  assign cpu_we_o   = we_q;
  assign cpu_addr_o = addr_q;
  assign cpu_dati_o = dati_q;

  assign req.done  = done_q;
  assign req.rdata = rdata_q;
  // Register port has no error response
  assign req.err   = 1'b0;

endmodule

/* hdl/dbg_system_top.sv */
/*
 * JTAG debug subsystem top
 * TAP, command unit, AHB master and CPU port on one hclk domain
 */

`timescale 1ns/100ps

`include "dbg_defs.svh"

module dbg_system_top (
  input  logic                   hclk_i,
  input  logic                   rst_n_i,
  // JTAG pins
  input  logic                   jtag_tck_i,
  input  logic                   jtag_tms_i,
  input  logic                   jtag_tdi_i,
  output logic                   jtag_tdo_o,
  output logic                   jtag_tdo_oe_o,
  // AHB-Lite debug master
  output logic                   ahb_hsel_o,
  output logic [`DBG_XLEN-1:0]   ahb_haddr_o,
  output logic [`DBG_XLEN-1:0]   ahb_hwdata_o,
  input  logic [`DBG_XLEN-1:0]   ahb_hrdata_i,
  output logic                   ahb_hwrite_o,
  output logic [2:0]             ahb_hsize_o,
  output logic [1:0]             ahb_htrans_o,
  input  logic                   ahb_hready_i,
  input  logic                   ahb_hresp_i,
  // CPU debug port
  output logic                   cpu_strb_o,
  output logic                   cpu_we_o,
  output logic [`DBG_CPU_AW-1:0] cpu_addr_o,
  output logic [`DBG_XLEN-1:0]   cpu_dati_o,
  input  logic [`DBG_XLEN-1:0]   cpu_dato_i,
  input  logic                   cpu_ack_i,
  input  logic                   cpu_bp_i,
  output logic                   cpu_stall_o,
  output logic                   sysrst_o
);

  logic [`DBG_XLEN-1:0] cpu_addr_full;

  dbg_tap_if tap_if ();
  dbg_req_if mem_if ();
  dbg_req_if cpu_if ();

  dbg_tap_ctrl u_tap (
    .hclk_i       (hclk_i),
    .rst_n_i      (rst_n_i),
    .jtag_tck_i   (jtag_tck_i),
    .jtag_tms_i   (jtag_tms_i),
    .jtag_tdi_i   (jtag_tdi_i),
    .jtag_tdo_o   (jtag_tdo_o),
    .jtag_tdo_oe_o(jtag_tdo_oe_o),
    .tap          (tap_if.tap)
  );

  dbg_cmd_unit u_cmd (
    .hclk_i     (hclk_i),
    .rst_n_i    (rst_n_i),
    .tap        (tap_if.dr),
    .mem        (mem_if.master),
    .cpu        (cpu_if.master),
    .cpu_bp_i   (cpu_bp_i),
    .cpu_stall_o(cpu_stall_o),
    .sys_rst_o  (sysrst_o)
  );

  dbg_ahb_master u_ahb (
    .hclk_i  (hclk_i),
    .rst_n_i (rst_n_i),
    .req     (mem_if.target),
    .hsel_o  (ahb_hsel_o),
    .haddr_o (ahb_haddr_o),
    .hwdata_o(ahb_hwdata_o),
    .hrdata_i(ahb_hrdata_i),
    .hwrite_o(ahb_hwrite_o),
    .hsize_o (ahb_hsize_o),
    .htrans_o(ahb_htrans_o),
    .hready_i(ahb_hready_i),
    .hresp_i (ahb_hresp_i)
  );

  dbg_cpu_port u_cpu (
    .hclk_i    (hclk_i),
    .rst_n_i   (rst_n_i),
    .req       (cpu_if.target),
    .cpu_strb_o(cpu_strb_o),
    .cpu_we_o  (cpu_we_o),
    .cpu_addr_o(cpu_addr_full),
    .cpu_dati_o(cpu_dati_o),
    .cpu_dato_i(cpu_dato_i),
    .cpu_ack_i (cpu_ack_i)
  );

  // Core decodes only the low register address bits
  assign cpu_addr_o = cpu_addr_full[`DBG_CPU_AW-1:0];

endmodule

/* dv/dbg_tb_asserts.sv */
/*
 * Bound protocol checks
 * Held signals stay stable while the target waits
 * Pulses last one cycle
 */

`timescale 1ns/100ps

module dbg_tb_asserts #(parameter int W = 33) (
  input logic         clk_i,
  input logic         rst_n_i,
  input logic         hold_i,
  input logic [W-1:0] held_i,
  input logic         pulse_i
);

  // Address, direction or strobe frozen during a wait
  a_held_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    hold_i |=> $stable(held_i))
    else $error("held signals changed during a wait cycle");

  // NONSEQ or req never on two cycles in a row
  a_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pulse_i |=> !pulse_i)
    else $error("pulse held for two cycles");

endmodule

// AHB waits are HREADY low
bind dbg_ahb_master dbg_tb_asserts #(.W(33)) u_ahb_asserts (
  .clk_i(hclk_i), .rst_n_i(rst_n_i), .hold_i(!hready_i),
  .held_i({hwrite_o, haddr_o}), .pulse_i(htrans_o == 2'b10)
);

// CPU strobe stays high until ack
bind dbg_cpu_port dbg_tb_asserts #(.W(33)) u_cpu_asserts (
  .clk_i(hclk_i), .rst_n_i(rst_n_i), .hold_i(cpu_strb_o && !cpu_ack_i),
  .held_i({cpu_strb_o, cpu_addr_o}), .pulse_i(req.req)
);

/* dv/dbg_tb.sv */
/*
 * Testbench for the JTAG debug subsystem
 * Drives JTAG scans, models the AHB memory and CPU debug registers
 */

`timescale 1ns/100ps

`include "dbg_defs.svh"

module dbg_tb;

  localparam int PERIOD    = 40;
  localparam int HALF      = 5;
  localparam int N_TESTS   = 6;
  localparam int MAX_SCANS = 48;
  localparam int SCAN_LEN  = 80;
  localparam int TIMEOUT   = N_TESTS * MAX_SCANS * SCAN_LEN * 8 * PERIOD;
  localparam int DRW       = `DBG_DR_W;

  logic        hclk = 1'b0;
  logic        rst_n = 1'b0;
  logic        tck = 1'b0, tms = 1'b1, tdi = 1'b0;
  logic        tdo, tdo_oe;
  logic        hsel, hwrite, hready = 1'b1, hresp = 1'b0;
  logic [31:0] haddr, hwdata, hrdata = '0;
  logic [2:0]  hsize;
  logic [1:0]  htrans;
  logic        strb, cwe, ack = 1'b0, bp = 1'b0, stall, sysrst;
  logic [15:0] caddr;
  logic [31:0] dati, dato = '0;

  logic [31:0] lfsr = 32'hfdf6ecc3;
  logic [31:0] mem [logic [31:0]];
  logic [31:0] regs [logic [15:0]];
  logic [31:0] seen_q [$];
  logic [31:0] err_addr = 32'hffff_fff0;
  logic        err_en = 1'b0, cpu_long = 1'b0;
  int          errors = 0, test_err = 0, failed_tests = 0;
  string       cur_test;

  dbg_system_top i_dut (
    .hclk_i(hclk), .rst_n_i(rst_n),
    .jtag_tck_i(tck), .jtag_tms_i(tms), .jtag_tdi_i(tdi),
    .jtag_tdo_o(tdo), .jtag_tdo_oe_o(tdo_oe),
    .ahb_hsel_o(hsel), .ahb_haddr_o(haddr), .ahb_hwdata_o(hwdata), .ahb_hrdata_i(hrdata),
    .ahb_hwrite_o(hwrite), .ahb_hsize_o(hsize), .ahb_htrans_o(htrans),
    .ahb_hready_i(hready), .ahb_hresp_i(hresp),
    .cpu_strb_o(strb), .cpu_we_o(cwe), .cpu_addr_o(caddr), .cpu_dati_o(dati),
    .cpu_dato_i(dato), .cpu_ack_i(ack), .cpu_bp_i(bp), .cpu_stall_o(stall),
    .sysrst_o(sysrst)
  );

  initial begin
    forever #(PERIOD / 2) hclk = ~hclk;
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // Unwritten words read back a pattern of the full address
  function automatic logic [31:0] mem_read(input logic [31:0] a);
    if (mem.exists(a))
      return mem[a];
    return {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
  endfunction

  task automatic note_failure(input string msg);
    $display("ERROR %0s: %0s", cur_test, msg);
    errors++;
    test_err++;
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("FAILED %0s %0s expected %h actual %h", cur_test, what, exp_v, act_v);
    errors++;
    test_err++;
  endtask

  //////////////////////////////
  // AHB slave model
  //////////////////////////////

  logic        pend = 1'b0, p_we;
  logic [31:0] p_addr;
  int          wcnt;

  always @(posedge hclk) begin
    if (!rst_n) begin
      hready <= 1'b1;
      hresp  <= 1'b0;
      pend    = 1'b0;
    end else if (pend) begin
      if (hready) begin
        // Data phase ends on this edge
        if (p_we)
          mem[p_addr] = hwdata;
        pend   = 1'b0;
        hresp <= 1'b0;
      end else if (wcnt == 0) begin
        hready <= 1'b1;
        hrdata <= mem_read(p_addr);
        hresp  <= err_en && (p_addr == err_addr);
      end else
        wcnt = wcnt - 1;
    end else if (hsel && htrans == 2'b10) begin
      // Debug accesses are single words
      if (hsize !== 3'b010)
        report_mismatch("hsize", 32'h2, {29'h0, hsize});
      seen_q.push_back(haddr);
      p_addr = haddr;
      p_we   = hwrite;
      pend   = 1'b1;
      wcnt   = int'(rand_bits(2));
      if (wcnt == 0) begin
        hrdata <= mem_read(haddr);
        hresp  <= err_en && (haddr == err_addr);
      end else begin
        hready <= 1'b0;
        wcnt    = wcnt - 1;
      end
    end
  end

  //////////////////////////////
  // CPU debug register model
  //////////////////////////////

  int cst = 0, ccnt;

  always @(posedge hclk) begin
    if (!rst_n) begin
      ack <= 1'b0;
      cst  = 0;
    end else begin
      case (cst)
        0: if (strb) begin
          ccnt = cpu_long ? 300 : int'(rand_bits(4));
          cst  = 1;
        end
        1: if (ccnt == 0) begin
          ack  <= 1'b1;
          dato <= regs.exists(caddr) ? regs[caddr] : 32'h0;
          if (cwe)
            regs[caddr] = dati;
          cst = 2;
        end else
          ccnt = ccnt - 1;
        // Strobe drops on this edge
        default: begin
          ack <= 1'b0;
          cst  = 0;
        end
      endcase
    end
  end

  //////////////////////////////
  // JTAG driver
  //////////////////////////////

  // One tck period with TDO sampled late in the low phase
  task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
    @(posedge hclk);
    tck <= 1'b0;
    tms <= tms_v;
    tdi <= tdi_v;
    repeat (HALF) @(posedge hclk);
    tdo_v = tdo;
    tck <= 1'b1;
    repeat (HALF - 1) @(posedge hclk);
  endtask

  task automatic scan_ir(input logic [3:0] ir);
    logic t;
    tck_cycle(1, 0, t);
    tck_cycle(1, 0, t);
    tck_cycle(0, 0, t);
    tck_cycle(0, 0, t);
    for (int i = 0; i < 4; i++)
      tck_cycle(i == 3, ir[i], t);
    tck_cycle(1, 0, t);
    tck_cycle(0, 0, t);
  endtask

  // TDO is driven only while in Shift-DR
  task automatic scan_dr(input logic [DRW-1:0] din, input int len,
                         output logic [DRW-1:0] dout);
    logic t;
    dout = '0;
    tck_cycle(1, 0, t);
    tck_cycle(0, 0, t);
    tck_cycle(0, 0, t);
    for (int i = 0; i < len; i++) begin
      tck_cycle(i == len - 1, din[i], t);
      dout[i] = t;
      if (tdo_oe !== 1'b1)
        note_failure("TDO output enable low during Shift-DR");
    end
    tck_cycle(1, 0, t);
    if (tdo_oe !== 1'b0)
      note_failure("TDO output enable still high after Shift-DR");
    tck_cycle(0, 0, t);
  endtask

  // Command update followed by a quick second update with no shift
  task automatic update_twice(input logic [DRW-1:0] din);
    logic t;
    tck_cycle(1, 0, t);
    tck_cycle(0, 0, t);
    tck_cycle(0, 0, t);
    for (int i = 0; i < DRW; i++)
      tck_cycle(i == DRW - 1, din[i], t);
    tck_cycle(1, 0, t);
    tck_cycle(1, 0, t);
    tck_cycle(0, 0, t);
    tck_cycle(1, 0, t);
    tck_cycle(1, 0, t);
    tck_cycle(0, 0, t);
  endtask

  // Status scans until busy reads low
  task automatic wait_idle(output logic [DRW-1:0] st);
    int n;
    n = 0;
    scan_dr('0, DRW, st);
    while (st[32] && n < 8) begin
      scan_dr('0, DRW, st);
      n++;
    end
    if (st[32])
      note_failure("command never left busy");
  endtask

  task automatic send_cmd(input logic [2:0] op, input logic [31:0] a, input logic [31:0] d,
                          output logic [DRW-1:0] st);
    logic [DRW-1:0] unused;
    scan_dr({op, a, d}, DRW, unused);
    wait_idle(st);
  endtask

  task automatic check_ahb_addr(input logic [31:0] a);
    logic [31:0] got;
    if (seen_q.size() == 0)
      note_failure("no AHB transfer seen");
    else begin
      got = seen_q.pop_front();
      if (got !== a)
        report_mismatch("haddr", a, got);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_err = 0;
  endtask

  task automatic end_test;
    if (test_err == 0)
      $display("test %0s ok", cur_test);
    else begin
      $display("test %0s had %0d errors", cur_test, test_err);
      failed_tests++;
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    logic [DRW-1:0] st, dout, din;
    logic [31:0]    a [8];
    logic [31:0]    d [8];
    logic [31:0]    ca, cd;
    logic [3:0]     instr [2];
    logic           t;

    repeat (3) @(posedge hclk);
    rst_n <= 1'b1;
    repeat (2) @(posedge hclk);

    begin_test("idcode");
    tck_cycle(0, 0, t);
    scan_dr('0, 32, dout);
    if (dout[31:0] !== `DBG_IDCODE)
      report_mismatch("idcode", `DBG_IDCODE, dout[31:0]);
    end_test();

    begin_test("bypass");
    instr[0] = 4'hF;
    instr[1] = 4'h3;
    for (int k = 0; k < 2; k++) begin
      scan_ir(instr[k]);
      din = {35'h0, rand_bits(32)};
      scan_dr(din, 32, dout);
      if (dout[31:0] !== {din[30:0], 1'b0})
        report_mismatch("tdo", {din[30:0], 1'b0}, dout[31:0]);
    end
    end_test();

    scan_ir(4'h8);

    begin_test("memory");
    for (int i = 0; i < 8; i++) begin
      a[i] = {rand_bits(24), 3'(i), 5'b0};
      d[i] = rand_bits(32);
      send_cmd(3'd2, a[i], d[i], st);
      check_ahb_addr(a[i]);
    end
    for (int i = 0; i < 8; i++) begin
      send_cmd(3'd1, a[i], 32'h0, st);
      check_ahb_addr(a[i]);
      if (st[31:0] !== d[i])
        report_mismatch("read data", d[i], st[31:0]);
    end
    end_test();

    begin_test("cpu_regs");
    for (int i = 0; i < 8; i++) begin
      ca = rand_bits(32);
      cd = rand_bits(32);
      send_cmd(3'd4, ca, cd, st);
      send_cmd(3'd3, ca, 32'h0, st);
      if (st[31:0] !== cd)
        report_mismatch("cpu read", cd, st[31:0]);
      if (regs[ca[15:0]] !== cd)
        report_mismatch("cpu reg", cd, regs[ca[15:0]]);
    end
    end_test();

    begin_test("stall_reset");
    send_cmd(3'd5, 32'h0, 32'h1, st);
    if (stall !== 1'b1 || sysrst !== 1'b0)
      report_mismatch("stall,sysrst", 32'h2, {30'h0, stall, sysrst});
    send_cmd(3'd5, 32'h0, 32'h2, st);
    if (stall !== 1'b0 || sysrst !== 1'b1)
      report_mismatch("stall,sysrst", 32'h1, {30'h0, stall, sysrst});
    send_cmd(3'd5, 32'h0, 32'h0, st);
    if (stall !== 1'b0 || sysrst !== 1'b0)
      report_mismatch("stall,sysrst", 32'h0, {30'h0, stall, sysrst});
    @(posedge hclk);
    bp <= 1'b1;
    @(posedge hclk);
    bp <= 1'b0;
    repeat (3) @(posedge hclk);
    if (stall !== 1'b1)
      note_failure("breakpoint did not set stall");
    wait_idle(st);
    if (st[35:34] !== 2'b11)
      report_mismatch("bp_seen,stall", 32'h3, {30'h0, st[35:34]});
    send_cmd(3'd5, 32'h0, 32'h4, st);
    end_test();

    begin_test("errors");
    err_en   = 1'b1;
    err_addr = {rand_bits(27), 5'b0};
    send_cmd(3'd1, err_addr, 32'h0, st);
    check_ahb_addr(err_addr);
    if (st[33] !== 1'b1)
      note_failure("AHB error response did not set err");
    send_cmd(3'd5, 32'h0, 32'h4, st);
    if (st[33] !== 1'b0)
      note_failure("CTRL clear left err set");
    cpu_long = 1'b1;
    update_twice({3'd3, 32'h0000_0010, 32'h0});
    cpu_long = 1'b0;
    wait_idle(st);
    if (st[33] !== 1'b1)
      note_failure("update while busy did not set err");
    send_cmd(3'd5, 32'h0, 32'h4, st);
    if (st[33] !== 1'b0)
      note_failure("CTRL clear left err set");
    end_test();

    $display("tests %0d, failed tests %0d, errors %0d", N_TESTS, failed_tests, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT);
    $display("Watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

/* project.f */
+incdir+include
hdl/dbg_pkg.sv
hdl/dbg_ifs.sv
hdl/dbg_tap_ctrl.sv
hdl/dbg_cmd_unit.sv
hdl/dbg_ahb_master.sv
hdl/dbg_cpu_port.sv
hdl/dbg_system_top.sv
dv/dbg_tb_asserts.sv
dv/dbg_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run, pass only if the pass message is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module dbg_tb -f project.f \
  -o sim_dbg &&
./obj_dir/sim_dbg | tee /dev/stderr | grep -q "Simulation passed" &&
echo "run_sim: PASS" ||
{ echo "run_sim: FAIL"; exit 1; }
